//--- lpcBoardPkg.sv
package lpcBoardPkg;

    //--------------------------------------------------------------------------
    // LPC I/O map and cycle field codes
    //--------------------------------------------------------------------------
    localparam logic [15:0] PostCodeAddr   = 16'h0080;   // Port 80 POST code
    localparam logic [15:0] BiosCtrlAddr   = 16'h0700;   // Flash swap control
    localparam logic [15:0] WdCtrlAddr     = 16'h0701;   // BIOS watchdog control
    localparam logic [3:0]  LpcStartCode   = 4'b0000;    // Start of a target cycle
    localparam logic [3:0]  LpcIoWriteType = 4'b0010;    // I/O space, write direction

    // Decoder phase codes, one per nibble of the cycle
    localparam logic [2:0] LpcStIdle  = 3'd0;   // Waiting for start
    localparam logic [2:0] LpcStType  = 3'd1;   // Cycle type nibble
    localparam logic [2:0] LpcStAddr3 = 3'd2;   // Address bits 15..12
    localparam logic [2:0] LpcStAddr2 = 3'd3;
    localparam logic [2:0] LpcStAddr1 = 3'd4;
    localparam logic [2:0] LpcStAddr0 = 3'd5;   // Address bits 3..0
    localparam logic [2:0] LpcStData0 = 3'd6;   // Low data nibble
    localparam logic [2:0] LpcStData1 = 3'd7;   // High data nibble

    //--------------------------------------------------------------------------
    // Seven segment patterns, bit 0 is segment a, low lights the segment
    //--------------------------------------------------------------------------
    localparam logic [6:0] SegHexTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,             // 0 1 2 3
        7'h19, 7'h12, 7'h02, 7'h78,             // 4 5 6 7
        7'h00, 7'h10, 7'h08, 7'h03,             // 8 9 A b
        7'h46, 7'h21, 7'h06, 7'h0E              // C d E F
    };

    // One written byte, read by field set according to the strobe
    typedef union packed {
        struct packed {
            logic [3:0] hi;                     // Left digit
            logic [3:0] lo;                     // Right digit
        } postCode;
        struct packed {
            logic [3:0] timeout;                // Watchdog ticks
            logic [1:0] reserved;               // Ignored
            logic       swapReq;                // Toggle active flash
            logic       enable;                 // Arm watchdog
        } control;
    } regData_u;

endpackage

//--- lpcRegIf.sv
interface lpcRegIf;
    import lpcBoardPkg::*;

    logic     postWr;       // POST code write strobe
    logic     biosCtrlWr;   // BIOS control write strobe
    logic     wdCtrlWr;     // Watchdog control write strobe
    regData_u data;         // Valid while a strobe is high

    modport decoder (
        output postWr,
        output biosCtrlWr,
        output wdCtrlWr,
        output data
    );

    modport sink (
        input postWr,
        input biosCtrlWr,
        input wdCtrlWr,
        input data
    );

endinterface

//--- lpcDecode.sv
module lpcDecode (
    input  logic       lpcClock,    // LPC bus clock
    input  logic       rstN,        // Async reset
    input  logic       lpcFrameN,   // LPC frame
    input  logic [3:0] lpcLad,      // LPC nibble bus, sampled only
    lpcRegIf.decoder   regBus       // Register write strobes
);
    import lpcBoardPkg::*;

    logic [2:0]  lpcState;          // Current nibble phase
    logic [15:0] ioAddr;            // Address shift register
    regData_u    wrData;            // Assembled write byte
    logic        cycleDone;         // Last data nibble taken

    //--------------------------------------------------------------------------
    // Cycle state machine
    //--------------------------------------------------------------------------
    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            lpcState  <= LpcStIdle;
            cycleDone <= 1'b0;
        end else if (!lpcFrameN) begin
            // Frame low restarts from any phase
            lpcState  <= (lpcLad == LpcStartCode) ? LpcStType : LpcStIdle;
            cycleDone <= 1'b0;
        end else begin
            cycleDone <= (lpcState == LpcStData1);
            case (lpcState)
                LpcStIdle:  lpcState <= LpcStIdle;          // Hold until next start
                LpcStType:  lpcState <= (lpcLad == LpcIoWriteType) ? LpcStAddr3 : LpcStIdle;
                LpcStData1: lpcState <= LpcStIdle;          // Cycle complete
                default:    lpcState <= lpcState + 3'd1;    // Next address or data nibble
            endcase
        end
    end

    // Address and data capture
    always_ff @(posedge lpcClock) begin
        if (lpcFrameN) begin
            case (lpcState)
                LpcStAddr3, LpcStAddr2, LpcStAddr1, LpcStAddr0: begin
                    ioAddr <= {ioAddr[11:0], lpcLad};       // MSB nibble first
                end
                LpcStData0: wrData.postCode.lo <= lpcLad;   // Low nibble first
                LpcStData1: wrData.postCode.hi <= lpcLad;
                default:    wrData <= wrData;
            endcase
        end
    end

    //--------------------------------------------------------------------------
    // Address compare and strobes
    //--------------------------------------------------------------------------
    // Strobe one edge after the last nibble; address holds until the next
    // cycle reaches its address phase
    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            regBus.postWr     <= 1'b0;
            regBus.biosCtrlWr <= 1'b0;
            regBus.wdCtrlWr   <= 1'b0;
        end else begin
            regBus.postWr     <= cycleDone && (ioAddr == PostCodeAddr);
            regBus.biosCtrlWr <= cycleDone && (ioAddr == BiosCtrlAddr);
            regBus.wdCtrlWr   <= cycleDone && (ioAddr == WdCtrlAddr);
        end
    end

    assign regBus.data = wrData;    // Stable until next data phase

    strobeOneHot: assert property (@(posedge lpcClock) disable iff (!rstN)
        $onehot0({regBus.postWr, regBus.biosCtrlWr, regBus.wdCtrlWr}))
        else $error("More than one register strobe");

endmodule

//--- biosWatchDog.sv
module biosWatchDog #(
    parameter int TickDiv = 32768       // Clocks per watchdog tick
) (
    input  logic  lpcClock,             // LPC bus clock
    input  logic  rstN,                 // Async reset
    lpcRegIf.sink regBus,               // Control register writes
    output logic  wdExpire              // One cycle expiry pulse
);

    logic [$clog2(TickDiv)-1:0] prescaler;  // Free running divider
    logic                       tick;       // Last prescaler count
    logic                       armed;      // Countdown running
    logic [3:0]                 wdCount;    // Ticks left before expiry

    assign tick = (prescaler == ($clog2(TickDiv))'(TickDiv - 1));

    //--------------------------------------------------------------------------
    // Tick prescaler
    //--------------------------------------------------------------------------
    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            prescaler <= '0;
        end else if (tick) begin
            prescaler <= '0;                // Wrap
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    //--------------------------------------------------------------------------
    // Countdown
    //--------------------------------------------------------------------------
    // Count holds timeout minus one so expiry lands on the timeout-th tick
    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            armed    <= 1'b0;
            wdCount  <= 4'd0;
            wdExpire <= 1'b0;
        end else begin
            wdExpire <= 1'b0;
            if (regBus.wdCtrlWr) begin
                armed <= regBus.data.control.enable;            // Kick or disarm
                if (regBus.data.control.timeout == 4'd0) begin
                    wdCount <= 4'd0;                            // Zero acts as one
                end else begin
                    wdCount <= regBus.data.control.timeout - 4'd1;
                end
            end else if (armed && tick) begin
                if (wdCount == 4'd0) begin
                    wdExpire <= 1'b1;       // Fire once
                    armed    <= 1'b0;       // Self disarm
                end else begin
                    wdCount <= wdCount - 4'd1;
                end
            end
        end
    end

    expireSingle: assert property (@(posedge lpcClock) disable iff (!rstN)
        wdExpire |=> !wdExpire)
        else $error("Watchdog expiry held two cycles");

endmodule

//--- biosControl.sv
module biosControl (
    input  logic       lpcClock,    // LPC bus clock
    input  logic       rstN,        // Async reset
    lpcRegIf.sink      regBus,      // Control register writes
    input  logic       wdExpire,    // Watchdog expiry pulse
    input  logic       biosSel,     // Jumper, 1 selects flash 0
    input  logic       spiCs0N,     // Host SPI chip select
    output logic [1:0] biosCsN,     // Per flash chip selects
    output logic [1:0] biosLedN     // Per flash LEDs
);

    logic swapped;      // Odd number of swaps since reset
    logic activeFlash;  // Flash index in use
    logic swapEvent;    // Software or watchdog swap

    assign swapEvent = (regBus.biosCtrlWr && regBus.data.control.swapReq) || wdExpire;

    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            swapped <= 1'b0;
        end else if (swapEvent) begin
            swapped <= ~swapped;    // One toggle even if both fire
        end
    end

    // Jumper default folded in here
    assign activeFlash = swapped ^ ~biosSel;

    //--------------------------------------------------------------------------
    // Chip select steering and LEDs
    //--------------------------------------------------------------------------
    assign biosCsN[0] = activeFlash ? 1'b1 : spiCs0N;   // Idle high when inactive
    assign biosCsN[1] = activeFlash ? spiCs0N : 1'b1;

    assign biosLedN[0] = activeFlash;       // Low when flash 0 active
    assign biosLedN[1] = ~activeFlash;      // Low when flash 1 active

    csExclusive: assert property (@(posedge lpcClock) disable iff (!rstN)
        biosCsN != 2'b00)
        else $error("Both flash chip selects low");

endmodule

//--- led7SegScan.sv
module led7SegScan #(
    parameter int ScanDiv = 32          // Clocks per digit
) (
    input  logic       lpcClock,        // LPC bus clock
    input  logic       rstN,            // Async reset
    lpcRegIf.sink      regBus,          // POST code writes
    output logic [1:0] led7DigitN,      // Digit enables, active low
    output logic [6:0] led7SegN         // Segments, active low
);
    import lpcBoardPkg::*;

    regData_u                   postReg;        // Latest POST code
    logic [$clog2(ScanDiv)-1:0] scanCnt;        // Hold time counter
    logic                       digitSel;       // 0 shows low nibble
    logic [3:0]                 shownNibble;    // Nibble on enabled digit

    //--------------------------------------------------------------------------
    // POST code register
    //--------------------------------------------------------------------------
    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            postReg <= '0;
        end else if (regBus.postWr) begin
            postReg <= regBus.data;
        end
    end

    //--------------------------------------------------------------------------
    // Digit scan
    //--------------------------------------------------------------------------
    always_ff @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            scanCnt  <= '0;
            digitSel <= 1'b0;
        end else if (scanCnt == ($clog2(ScanDiv))'(ScanDiv - 1)) begin
            scanCnt  <= '0;
            digitSel <= ~digitSel;          // Next digit
        end else begin
            scanCnt <= scanCnt + 1'b1;
        end
    end

    // Enable and segments both follow digitSel
    assign led7DigitN  = digitSel ? 2'b01 : 2'b10;
    assign shownNibble = digitSel ? postReg.postCode.hi : postReg.postCode.lo;
    assign led7SegN    = SegHexTable[shownNibble];

    digitOneHot: assert property (@(posedge lpcClock) disable iff (!rstN)
        $onehot(~led7DigitN))
        else $error("Digit enables not one-hot");

endmodule

//--- lpcBoardCtrl.sv
module lpcBoardCtrl #(
    parameter int TickDiv = 32768,      // Watchdog tick length
    parameter int ScanDiv = 32          // Display digit hold
) (
    input  logic       lpcClock,        // LPC bus clock
    input  logic       rstN,            // Async reset
    input  logic       lpcFrameN,       // LPC frame
    input  logic [3:0] lpcLad,          // LPC nibble bus
    input  logic       spiCs0N,         // Host SPI chip select
    input  logic       biosSel,         // BIOS select jumper
    output logic [1:0] biosCsN,         // Flash chip selects
    output logic [1:0] biosLedN,        // Active flash LEDs
    output logic [1:0] led7DigitN,      // Display digit enables
    output logic [6:0] led7SegN         // Display segments
);

    lpcRegIf regBus ();                 // Decoder to register users

    logic wdExpire;                     // Watchdog to flash control

    //--------------------------------------------------------------------------
    // Decode, execute and display
    //--------------------------------------------------------------------------
    lpcDecode u_lpcDecode (
        .lpcClock  (lpcClock),
        .rstN      (rstN),
        .lpcFrameN (lpcFrameN),
        .lpcLad    (lpcLad),
        .regBus    (regBus.decoder)
    );

    biosWatchDog #(
        .TickDiv (TickDiv)
    ) u_biosWatchDog (
        .lpcClock (lpcClock),
        .rstN     (rstN),
        .regBus   (regBus.sink),
        .wdExpire (wdExpire)
    );

    biosControl u_biosControl (
        .lpcClock (lpcClock),
        .rstN     (rstN),
        .regBus   (regBus.sink),
        .wdExpire (wdExpire),
        .biosSel  (biosSel),
        .spiCs0N  (spiCs0N),
        .biosCsN  (biosCsN),
        .biosLedN (biosLedN)
    );

    led7SegScan #(
        .ScanDiv (ScanDiv)
    ) u_led7SegScan (
        .lpcClock   (lpcClock),
        .rstN       (rstN),
        .regBus     (regBus.sink),
        .led7DigitN (led7DigitN),
        .led7SegN   (led7SegN)
    );

endmodule

//--- tbLpcBoardCtrl.sv
module tbLpcBoardCtrl;
    timeunit 1ns;
    timeprecision 100ps;
    import lpcBoardPkg::*;

    localparam int TickDiv   = 16;
    localparam int ScanDiv   = 4;
    localparam int NumIter   = 8;                       // Random rounds per test
    localparam int CycleLen  = 11;                      // Nibbles plus strobe latency
    localparam int WdMax     = 16 * TickDiv + 4;        // Longest watchdog window
    localparam int MaxCycles = 2 * (NumIter * 5 * (3 * CycleLen + 6 * ScanDiv + 16)
                                    + 12 * WdMax);      // Twice the summed test lengths

    logic       lpcClock, rstN, lpcFrameN, spiCs0N, biosSel;
    logic [3:0] lpcLad;
    logic [1:0] biosCsN, biosLedN, led7DigitN;
    logic [6:0] led7SegN;

    logic [31:0] seed = 32'h60b2c866;
    logic [7:0]  postModel;             // Expected POST code
    logic        activeModel;           // Expected active flash
    int          sinceReset = 0;        // Clock edges since reset release
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    lpcBoardCtrl #(.TickDiv(TickDiv), .ScanDiv(ScanDiv)) u_lpcBoardCtrl (
        .lpcClock(lpcClock), .rstN(rstN), .lpcFrameN(lpcFrameN), .lpcLad(lpcLad),
        .spiCs0N(spiCs0N), .biosSel(biosSel), .biosCsN(biosCsN), .biosLedN(biosLedN),
        .led7DigitN(led7DigitN), .led7SegN(led7SegN)
    );

    initial begin
        lpcClock = 1'b0;
        forever #20 lpcClock = ~lpcClock;   // 40 ns period
    end

    // Display scan position, digit 0 first after reset
    always @(posedge lpcClock or negedge rstN) begin
        if (!rstN) begin
            sinceReset <= 0;
        end else begin
            sinceReset <= sinceReset + 1;
        end
    end

    //--------------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("ERROR %s %s expected %0h actual %0h", testName, what, expected, actual);
        end
    endtask

    // Drives the first count nibbles of a cycle, one per rising edge
    task automatic sendNibbles(input logic [3:0] cycType, input logic [15:0] addr,
                               input logic [7:0] data, input int count);
        logic [3:0] nibbles [8];
        nibbles = '{LpcStartCode, cycType, addr[15:12], addr[11:8],
                    addr[7:4], addr[3:0], data[3:0], data[7:4]};
        for (int i = 0; i < count; i++) begin
            @(posedge lpcClock);
            lpcFrameN <= (i != 0);          // Frame low with start only
            lpcLad    <= nibbles[i];
        end
    endtask

    task automatic writeCycle(input logic [3:0] cycType, input logic [15:0] addr,
                              input logic [7:0] data);
        sendNibbles(cycType, addr, data, 8);
        repeat (3) @(posedge lpcClock);     // Sample, strobe, register update
        if (cycType == LpcIoWriteType && addr == PostCodeAddr)
            postModel = data;
        if (cycType == LpcIoWriteType && addr == BiosCtrlAddr && data[1])
            activeModel = !activeModel;     // Swap request bit
    endtask

    task automatic checkOutputs(input string testName);
        logic [3:0] nib;
        logic [1:0] digitModel;
        @(negedge lpcClock);
        digitModel = ((sinceReset / ScanDiv) % 2 == 0) ? 2'b10 : 2'b01;
        nib = (digitModel == 2'b10) ? postModel[3:0] : postModel[7:4];
        checkValue(testName, "digit", 32'(digitModel), 32'(led7DigitN));
        checkValue(testName, "seg", 32'(SegHexTable[nib]), 32'(led7SegN));
        checkValue(testName, "led", 32'({!activeModel, activeModel}), 32'(biosLedN));
        checkValue(testName, "cs", activeModel ? 32'({spiCs0N, 1'b1}) : 32'({1'b1, spiCs0N}),
                   32'(biosCsN));
    endtask

    task automatic checkSpan(input string testName, input int cycles);
        repeat (cycles) checkOutputs(testName);
    endtask

    // Counts cycles until the flash swaps, bounded past the window end
    task automatic waitSwap(input int lo, input int hi);
        int n;
        n = 0;
        @(negedge lpcClock);
        while (biosLedN[0] == activeModel && n <= hi + 8) begin
            @(negedge lpcClock);
            n++;
        end
        checkCount++;
        if (n < lo || n > hi) begin
            errorCount++;
            $display("Watchdog swap seen after %0d cycles, outside %0d to %0d", n, lo, hi);
        end
        if (biosLedN[0] != activeModel)
            activeModel = !activeModel;     // Follow the swap
    endtask

    task automatic reportTest(input string testName, input int errBefore);
        $display("Test %-16s done, %0d errors", testName, errorCount - errBefore);
    endtask

    //--------------------------------------------------------------------------
    // Stimulus
    //--------------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [15:0] addr;
        int          errBefore;
        int          t;
        rstN      = 1'b0;
        lpcFrameN = 1'b1;
        lpcLad    = 4'hF;
        spiCs0N   = 1'b1;
        biosSel   = 1'b1;

        errBefore = errorCount;
        for (int k = 0; k < NumIter; k++) begin
            r = nextRandom();
            @(posedge lpcClock);
            biosSel <= r[0];
            rstN    <= 1'b0;
            repeat (8) @(posedge lpcClock);
            rstN <= 1'b1;
            activeModel = !r[0];            // Jumper rule
            postModel   = 8'h00;
            @(negedge lpcClock);
            checkValue("reset", "first digit", 32'(2'b10), 32'(led7DigitN));
            checkSpan("reset", 2 * ScanDiv);
        end
        reportTest("reset", errBefore);

        errBefore = errorCount;
        for (int k = 0; k < NumIter; k++) begin
            r = nextRandom();
            writeCycle(LpcIoWriteType, PostCodeAddr, r[7:0]);
            checkSpan("post code", 6 * ScanDiv);    // Three scan periods
        end
        reportTest("post code", errBefore);

        errBefore = errorCount;
        for (int k = 0; k < NumIter; k++) begin
            r = nextRandom();
            addr = r[31:16];
            if (addr == PostCodeAddr || addr == BiosCtrlAddr || addr == WdCtrlAddr)
                addr = addr ^ 16'h8000;     // Keep it unmapped
            writeCycle(LpcIoWriteType, addr, r[7:0]);
            writeCycle((r[11:8] == LpcIoWriteType) ? 4'h3 : r[11:8], PostCodeAddr, r[15:8]);
            writeCycle((r[3:0] == LpcIoWriteType) ? 4'h3 : r[3:0], BiosCtrlAddr, 8'h02);
            checkSpan("ignored", 2 * ScanDiv);
            sendNibbles(LpcIoWriteType, BiosCtrlAddr, 8'h02, 1 + int'(r[6:4]) % 7);
            @(posedge lpcClock);
            lpcFrameN <= 1'b0;              // Abort with a non-start nibble
            lpcLad    <= {r[3:1], 1'b1};
            writeCycle(LpcIoWriteType, PostCodeAddr, r[15:8]);
            sendNibbles(LpcIoWriteType, BiosCtrlAddr, 8'h02, 1 + int'(r[9:7]) % 7);
            writeCycle(LpcIoWriteType, PostCodeAddr, r[31:24]);   // Restart mid-cycle
            checkSpan("ignored", 2 * ScanDiv);
        end
        reportTest("ignored", errBefore);

        errBefore = errorCount;
        for (int k = 0; k < NumIter; k++) begin
            r = nextRandom();
            writeCycle(LpcIoWriteType, BiosCtrlAddr, r[7:0]);
            repeat (4) begin
                r = nextRandom();
                @(posedge lpcClock);
                spiCs0N <= r[0];
                checkOutputs("swap");
            end
        end
        reportTest("swap", errBefore);

        errBefore = errorCount;
        for (int k = 0; k < 3; k++) begin
            r = nextRandom();
            t = (r[7:4] == 4'd0) ? 1 : int'(r[7:4]);    // Zero acts as one
            writeCycle(LpcIoWriteType, WdCtrlAddr, {r[7:4], r[3:2], 2'b01});
            waitSwap((t - 1) * TickDiv, t * TickDiv + 2);
            checkOutputs("watchdog expiry");
        end
        reportTest("watchdog expiry", errBefore);

        errBefore = errorCount;
        r = nextRandom();
        t = 3 + int'(r[3:0]) % 13;
        for (int k = 0; k < 4; k++) begin
            writeCycle(LpcIoWriteType, WdCtrlAddr, {4'(t), 4'b0001});
            repeat ((t - 1) * TickDiv - 16) @(posedge lpcClock);   // Kick well inside window
            checkOutputs("watchdog kick");
        end
        writeCycle(LpcIoWriteType, WdCtrlAddr, 8'h00);
        repeat (WdMax) @(posedge lpcClock);
        checkOutputs("watchdog kick");
        reportTest("watchdog kick", errBefore);

        // Timeout of at least eight ticks so the disarm lands before any expiry
        errBefore = errorCount;
        r = nextRandom();
        writeCycle(LpcIoWriteType, WdCtrlAddr, {1'b1, r[6:4], 4'b0001});
        writeCycle(LpcIoWriteType, WdCtrlAddr, {1'b1, r[6:4], 4'b0000});
        repeat (WdMax) @(posedge lpcClock);
        checkOutputs("watchdog disarm");
        reportTest("watchdog disarm", errBefore);

        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycleCount < MaxCycles) begin
            @(posedge lpcClock);
            cycleCount++;
        end
        $display("Run stopped at cycle limit %0d before the tests finished", MaxCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- lpcBoardCtrl.f
lpcBoardPkg.sv
lpcRegIf.sv
lpcDecode.sv
biosWatchDog.sv
biosControl.sv
led7SegScan.sv
lpcBoardCtrl.sv
tbLpcBoardCtrl.sv

//--- Makefile
TOP := tbLpcBoardCtrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f lpcBoardCtrl.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir
